//--- source/serdes_pkg.sv
package serdes_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lane geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int WORD_WIDTH = 8;                        // Bits per parallel word
    localparam int BIT_CNT_WIDTH = $clog2(WORD_WIDTH);    // Bit position counter width

    typedef logic [WORD_WIDTH-1:0] word_t;                // One parallel word
    typedef logic [BIT_CNT_WIDTH-1:0] bit_cnt_t;          // Bit position within a word

    // Alignment and idle fill, sent LSB first as 0,0,1,1,1,1,0,1
    localparam word_t COMMA_WORD = 8'hbc;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Receive path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int DELAY_TAPS = 5;                        // Fixed input delay, in cycles

    typedef enum logic [0:0] {
        RX_HUNT,                                          // Searching for the comma
        RX_LOCKED                                         // Word phase fixed
    } rx_state_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Transmit buffer and lane reset
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int CREDIT_DEPTH = 2;                      // Buffer slots = initial credits
    localparam int FIFO_PTR_WIDTH = $clog2(CREDIT_DEPTH);
    localparam int FIFO_CNT_WIDTH = $clog2(CREDIT_DEPTH + 1);

    localparam int LANE_RST_CYCLES = 4;                   // Stretch after RST falls
    localparam int RST_CNT_WIDTH = $clog2(LANE_RST_CYCLES + 1);

endpackage

//--- source/serdes_reset_seq.sv
`timescale 1ns/1ps

module serdes_reset_seq (
    input  logic CLKDIV,
    input  logic RST,
    output logic lane_rst
);

    logic [serdes_pkg::RST_CNT_WIDTH-1:0] rst_cnt;        // Remaining stretch cycles

    always_ff @(posedge CLKDIV) begin
        if (RST) begin
            rst_cnt <= serdes_pkg::RST_CNT_WIDTH'(serdes_pkg::LANE_RST_CYCLES);
        end else if (rst_cnt != '0) begin
            rst_cnt <= rst_cnt - 1'b1;                     // Count down the stretch
        end
    end

    // Held through RST itself, then until the count runs out
    assign lane_rst = RST || (rst_cnt != '0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_rst_stretch: assert property (
        @(posedge CLKDIV) $fell(RST) |-> lane_rst [*serdes_pkg::LANE_RST_CYCLES]
    ) else $error("lane_rst released early after RST");

endmodule

//--- source/serdes_serializer.sv
`timescale 1ns/1ps

module serdes_serializer (
    input  logic              CLKDIV,
    input  logic              lane_rst,
    input  logic              in_valid,
    input  serdes_pkg::word_t in_word,
    output logic              in_credit,
    output logic              o_dat,
    output logic              t_dat
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Credit buffer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    serdes_pkg::word_t                     fifo_mem [serdes_pkg::CREDIT_DEPTH];
    logic [serdes_pkg::FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [serdes_pkg::FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [serdes_pkg::FIFO_CNT_WIDTH-1:0] fifo_count;
    logic                                  fifo_empty;
    logic                                  fifo_pop;

    // Shifter
    serdes_pkg::word_t    shift_reg;                      // Bits still to send
    serdes_pkg::bit_cnt_t bit_pos;                        // Position in current word
    serdes_pkg::word_t    tx_word;                        // Word framed at next boundary
    logic                 word_boundary;

    function automatic logic [serdes_pkg::FIFO_PTR_WIDTH-1:0] ptr_next(
        input logic [serdes_pkg::FIFO_PTR_WIDTH-1:0] ptr
    );
        if (ptr == serdes_pkg::FIFO_PTR_WIDTH'(serdes_pkg::CREDIT_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign fifo_empty    = (fifo_count == '0);
    assign word_boundary = (bit_pos == '0);
    assign fifo_pop      = word_boundary && !fifo_empty;  // Head moves into the shifter
    assign tx_word       = fifo_empty ? serdes_pkg::COMMA_WORD : fifo_mem[rd_ptr];

    always_ff @(posedge CLKDIV) begin
        if (in_valid) begin
            fifo_mem[wr_ptr] <= in_word;
        end
    end

    always_ff @(posedge CLKDIV) begin
        if (lane_rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (fifo_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({in_valid, fifo_pop})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;      // Idle, or push and pop together
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Shift out, LSB first
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge CLKDIV) begin
        if (lane_rst) begin
            bit_pos   <= '0;
            o_dat     <= 1'b0;
            t_dat     <= 1'b1;                             // Pad tri-stated
            in_credit <= 1'b0;
        end else begin
            bit_pos   <= bit_pos + 1'b1;                   // Wraps every WORD_WIDTH
            t_dat     <= 1'b0;
            in_credit <= fifo_pop;                         // One credit back per pop
            o_dat     <= word_boundary ? tx_word[0] : shift_reg[0];
        end
    end

    always_ff @(posedge CLKDIV) begin
        if (word_boundary) begin
            shift_reg <= tx_word >> 1;
        end else begin
            shift_reg <= shift_reg >> 1;
        end
    end

    // Sender must hold a credit for every write
    a_no_overflow: assert property (
        @(posedge CLKDIV) disable iff (lane_rst)
        in_valid |-> (fifo_count < serdes_pkg::FIFO_CNT_WIDTH'(serdes_pkg::CREDIT_DEPTH))
    ) else $error("in_valid while transmit buffer full");

endmodule

//--- source/serdes_delay_line.sv
`timescale 1ns/1ps

module serdes_delay_line (
    input  logic CLKDIV,
    input  logic lane_rst,
    input  logic i_dat,
    output logic dly_bit
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fixed tap chain
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [serdes_pkg::DELAY_TAPS-1:0] taps;              // taps[0] is the newest bit

    always_ff @(posedge CLKDIV) begin
        if (lane_rst) begin
            taps <= '0;                                    // Line reads 0 until released
        end else begin
            taps <= {taps[serdes_pkg::DELAY_TAPS-2:0], i_dat};
        end
    end

    // Bit leaves after DELAY_TAPS cycles in the chain
    assign dly_bit = taps[serdes_pkg::DELAY_TAPS-1];

endmodule

//--- source/serdes_deserializer.sv
`timescale 1ns/1ps

module serdes_deserializer (
    input  logic              CLKDIV,
    input  logic              lane_rst,
    input  logic              dly_bit,
    output logic              out_valid,
    output serdes_pkg::word_t out_word,
    output logic              locked
);

    serdes_pkg::rx_state_t rx_state;
    serdes_pkg::word_t     window;                        // Last WORD_WIDTH bits received
    serdes_pkg::word_t     next_window;
    serdes_pkg::bit_cnt_t  bit_cnt;                       // Bits of current word so far
    logic                  comma_seen;
    logic                  word_done;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Receive window
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // New bit enters at the top, so the earliest bit ends up in bit 0
    assign next_window = {dly_bit, window[serdes_pkg::WORD_WIDTH-1:1]};

    assign comma_seen = (window == serdes_pkg::COMMA_WORD);
    assign locked     = (rx_state == serdes_pkg::RX_LOCKED);
    assign word_done  = locked && (bit_cnt == '1);        // Last bit of word arriving

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Hunt and framing FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge CLKDIV) begin
        if (lane_rst) begin
            rx_state  <= serdes_pkg::RX_HUNT;
            window    <= '0;
            bit_cnt   <= '0;
            out_valid <= 1'b0;
        end else begin
            window    <= next_window;
            out_valid <= word_done && (next_window != serdes_pkg::COMMA_WORD);
            case (rx_state)
                serdes_pkg::RX_HUNT: begin
                    if (comma_seen) begin
                        rx_state <= serdes_pkg::RX_LOCKED;
                        // Bit shifting in now opens the next word
                        bit_cnt  <= serdes_pkg::bit_cnt_t'(1);
                    end
                end
                serdes_pkg::RX_LOCKED: begin
                    bit_cnt <= bit_cnt + 1'b1;             // Phase stays fixed once locked
                end
                default: begin
                    rx_state <= serdes_pkg::RX_HUNT;
                end
            endcase
        end
    end

    // Holds the last completed word between boundaries
    always_ff @(posedge CLKDIV) begin
        if (word_done) begin
            out_word <= next_window;
        end
    end

    a_valid_locked: assert property (
        @(posedge CLKDIV) disable iff (lane_rst) out_valid |-> locked
    ) else $error("out_valid without lock");

endmodule

//--- source/serdes_loopback_top.sv
`timescale 1ns/1ps

module serdes_loopback_top (
    input  logic              CLKDIV,
    input  logic              RST,

    // Parallel transmit side, credit flow control
    input  logic              in_valid,
    input  serdes_pkg::word_t in_word,
    output logic              in_credit,

    // Serial pad
    output logic              o_dat,
    output logic              t_dat,
    input  logic              i_dat,

    // Parallel receive side
    output logic              out_valid,
    output serdes_pkg::word_t out_word,
    output logic              locked
);

    logic lane_rst;                                       // Stretched lane reset
    logic dly_bit;                                        // Serial bit after delay

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reset and transmit
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    serdes_reset_seq u_serdes_reset_seq (
        .CLKDIV   (CLKDIV),
        .RST      (RST),
        .lane_rst (lane_rst)
    );

    serdes_serializer u_serdes_serializer (
        .CLKDIV    (CLKDIV),
        .lane_rst  (lane_rst),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .in_credit (in_credit),
        .o_dat     (o_dat),
        .t_dat     (t_dat)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Receive
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    serdes_delay_line u_serdes_delay_line (
        .CLKDIV   (CLKDIV),
        .lane_rst (lane_rst),
        .i_dat    (i_dat),
        .dly_bit  (dly_bit)
    );

    serdes_deserializer u_serdes_deserializer (
        .CLKDIV    (CLKDIV),
        .lane_rst  (lane_rst),
        .dly_bit   (dly_bit),
        .out_valid (out_valid),
        .out_word  (out_word),
        .locked    (locked)
    );

endmodule

//--- tests/serdes_loopback_tb.sv
`timescale 1ns/1ps

module serdes_loopback_tb;

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 2;
    localparam int RESET_SPAN = RST_CYCLES + serdes_pkg::LANE_RST_CYCLES;
    localparam int LOCK_LIMIT = (2 + serdes_pkg::DELAY_TAPS) * serdes_pkg::WORD_WIDTH;
    localparam int MAX_WORDS  = 64;
    localparam int DRAIN_CYCLES = 3 * serdes_pkg::WORD_WIDTH;  // Window for stray words

    logic              CLKDIV = 1'b0;
    logic              RST;
    logic              in_valid;
    serdes_pkg::word_t in_word;
    logic              in_credit;
    logic              o_dat;
    logic              t_dat;
    logic              i_dat = 1'b0;
    logic              out_valid;
    serdes_pkg::word_t out_word;
    logic              locked;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test data and scoreboard
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [15:0]       test_mem [0:2*MAX_WORDS-1];         // Word, gap, word, gap ...
    serdes_pkg::word_t words [MAX_WORDS];
    int                gaps [MAX_WORDS];
    int                num_words = 0;
    int                gap_sum = 0;
    logic              tests_loaded = 1'b0;
    serdes_pkg::word_t expected_q [$];
    logic [31:0]       rng_state = 32'hb3f7;

    int edge_count = 0;
    int words_sent = 0;
    int words_received = 0;
    int credits_returned = 0;
    int valid_cycles = 0;
    int value_errors = 0;
    int other_errors = 0;
    logic lock_seen = 1'b0;

    always #(CLK_PERIOD / 2) CLKDIV = ~CLKDIV;

    serdes_loopback_top u_serdes_loopback_top (
        .CLKDIV    (CLKDIV),
        .RST       (RST),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .in_credit (in_credit),
        .o_dat     (o_dat),
        .t_dat     (t_dat),
        .i_dat     (i_dat),
        .out_valid (out_valid),
        .out_word  (out_word),
        .locked    (locked)
    );

    // Pad loopback, line pulled low while tri-stated
    always @(posedge CLKDIV) begin
        #1;
        i_dat = t_dat ? 1'b0 : o_dat;
    end

    always @(posedge CLKDIV) begin
        edge_count <= edge_count + 1;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s at %0t: got 0x%0h, expected 0x%0h",
                     name, $time, actual, expected);
            value_errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        other_errors++;
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic advance_cycle();
        @(posedge CLKDIV);
        #1;                                                // Drive just after the edge
    endtask

    task automatic load_tests();
        for (int i = 0; i < 2 * MAX_WORDS; i++) begin
            test_mem[i] = 16'hffff;                        // End marker
        end
        $readmemh("tests/serdes_tests.dat", test_mem);
        while (num_words < MAX_WORDS && test_mem[2*num_words] != 16'hffff) begin
            words[num_words] = test_mem[2*num_words][7:0];
            gaps[num_words]  = int'(test_mem[2*num_words+1]);
            if (words[num_words] == serdes_pkg::COMMA_WORD) begin
                report_error($sformatf("data file line %0d holds the comma word", num_words));
            end
            gap_sum += gaps[num_words];
            num_words++;
        end
        if (num_words == 0) begin
            report_error("data file holds no words");
        end
    endtask

    task automatic send_words();
        int gap;
        for (int i = 0; i < num_words; i++) begin
            gap = gaps[i];
            if (gap != 0) begin                            // Zero-gap runs stay back to back
                rng_state = lcg_step(rng_state);
                gap += int'(rng_state[17:16]);
            end
            repeat (gap) begin
                in_valid = 1'b0;
                advance_cycle();
            end
            while (words_sent - credits_returned >= serdes_pkg::CREDIT_DEPTH) begin
                in_valid = 1'b0;                           // Out of credit
                advance_cycle();
            end
            in_valid = 1'b1;
            in_word  = words[i];
            expected_q.push_back(words[i]);
            words_sent++;
            advance_cycle();
        end
        in_valid = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output monitor, sampled mid-cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge CLKDIV) begin
        if (edge_count != 0) begin
            if (edge_count <= RESET_SPAN) begin
                check_value("t_dat", 32'(t_dat), 32'd1);
                check_value("o_dat", 32'(o_dat), 32'd0);
                check_value("out_valid", 32'(out_valid), 32'd0);
                check_value("locked", 32'(locked), 32'd0);
                check_value("in_credit", 32'(in_credit), 32'd0);
            end else begin
                check_value("t_dat", 32'(t_dat), 32'd0);
            end
            if (in_credit) credits_returned++;
            if (in_valid) valid_cycles++;
            if (credits_returned > valid_cycles) begin
                report_error("in_credit returned a credit with no word outstanding");
            end
            if (locked) begin
                lock_seen = 1'b1;
            end else if (lock_seen) begin
                report_error("lane dropped lock");
            end
            if (out_valid) begin
                if (!locked) report_error("out_valid while not locked");
                if (out_word == serdes_pkg::COMMA_WORD) report_error("comma delivered as data");
                if (expected_q.size() == 0) begin
                    report_error($sformatf("unexpected word 0x%02h", out_word));
                end else begin
                    check_value("out_word", 32'(out_word), 32'(expected_q.pop_front()));
                end
                words_received++;
            end
        end
    end

    initial begin : watchdog
        int limit_cycles;
        wait (tests_loaded);
        limit_cycles = num_words * serdes_pkg::WORD_WIDTH * 4 + gap_sum + 400;
        #(limit_cycles * CLK_PERIOD);
        $display("Timeout after %0d cycles, only %0d of %0d words arrived",
                 limit_cycles, words_received, num_words);
        for (int i = words_received; i < num_words; i++) begin
            $display("Word %0d (0x%02h) never arrived", i, words[i]);
        end
        $display("Summary: %0d value errors, %0d other errors",
                 value_errors, other_errors + 1);
        $display("Test FAILED");
        $finish;
    end

    initial begin : main_seq
        int lock_wait;
        RST      = 1'b1;
        in_valid = 1'b0;
        in_word  = '0;
        load_tests();
        tests_loaded = 1'b1;

        repeat (RST_CYCLES) @(posedge CLKDIV);
        #1;
        RST = 1'b0;
        repeat (serdes_pkg::LANE_RST_CYCLES) @(posedge CLKDIV);
        #1;

        // Only commas on the line until lock
        lock_wait = 0;
        while (!locked && lock_wait < LOCK_LIMIT) begin
            advance_cycle();
            lock_wait++;
        end

        if (!locked) begin
            report_error($sformatf("no lock within %0d cycles of lane release", LOCK_LIMIT));
        end else begin
            send_words();
            while (words_received < num_words) begin
                advance_cycle();
            end
            repeat (DRAIN_CYCLES) advance_cycle();
            check_value("credits_returned", 32'(credits_returned), 32'(valid_cycles));
            check_value("words_received", 32'(words_received), 32'(num_words));
        end

        $display("Summary: %0d value errors, %0d other errors, %0d of %0d words received",
                 value_errors, other_errors, words_received, num_words);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- tests/serdes_tests.dat
// Columns: data word (hex, never bc), idle gap in cycles before the word (hex)
// Sections: sparse words, back-to-back run, long idle fill, back-to-back tail
3a 10
c5 05
00 0c
ff 08
5e 14
01 00
02 00
04 00
08 00
10 00
20 00
40 00
80 00
a5 00
5a 00
3c 00
c3 00
7e 40
81 60
bd 80
bb 50
de 00
ad 00
be 00
ef 00
12 00
34 00
56 00
78 00
9a 00
f0 04
0f 00

//--- filelist.f
source/serdes_pkg.sv
source/serdes_reset_seq.sv
source/serdes_serializer.sv
source/serdes_delay_line.sv
source/serdes_deserializer.sv
source/serdes_loopback_top.sv
tests/serdes_loopback_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := serdes_loopback_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
PASS_MSG  := Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		exit 0; \
	else \
		echo "Simulation did not pass"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
